//--- files.f
+incdir+tb
logic/dll_tx_pkg.sv
logic/tlp_skid_buffer.sv
logic/fc_credit_gate.sv
logic/lcrc32_step.sv
logic/dllp_framer.sv
logic/tlp_tx_datalink.sv
tb/tb_tlp_tx_datalink.sv

//--- logic/dll_tx_pkg.sv
package dll_tx_pkg;

  localparam int SEQ_W = 12;
  localparam int FC_W = 8;
  // largest usable distance between limit and consumed
  localparam int FC_WINDOW = 128;

  localparam logic [31:0] LCRC_INIT = 32'hFFFF_FFFF;
  localparam logic [31:0] LCRC_POLY_REFL = 32'hEDB8_8320;

  // type field codes that matter for credit classing
  localparam logic [4:0] TYPE_MEM = 5'b00000;
  localparam logic [4:0] TYPE_CPL = 5'b01010;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } tlp_beat_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
  } dllp_beat_t;

  // first header dword, byte 0 sits in bits 7:0
  typedef struct packed {
    logic [7:0] length_lo;
    logic       td;
    logic       ep;
    logic [1:0] attr_lo;
    logic [1:0] at;
    logic [1:0] length_hi;
    logic       t9;
    logic [2:0] tc;
    logic       t8;
    logic       attr_hi;
    logic       ln;
    logic       th;
    logic [2:0] fmt;
    logic [4:0] tlp_type;
  } tlp_dw0_hdr_t;

  typedef union packed {
    logic [31:0]  raw;
    tlp_dw0_hdr_t hdr;
  } tlp_dw0_u;

  typedef enum logic [1:0] {
    CLASS_P   = 2'd0,
    CLASS_NP  = 2'd1,
    CLASS_CPL = 2'd2
  } tlp_class_e;

  typedef struct packed {
    logic [FC_W-1:0] cplh;
    logic [FC_W-1:0] nph;
    logic [FC_W-1:0] ph;
  } fc_limits_t;

endpackage

//--- logic/dllp_framer.sv
module dllp_framer (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  dll_tx_pkg::tlp_beat_t          head_i,
  input  logic                           head_valid_i,
  output logic                           head_ready_o,
  input  logic                           admit_i,
  input  dll_tx_pkg::tlp_class_e         head_class_i,
  output dll_tx_pkg::dllp_beat_t         out_beat_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic                           frame_done_o,
  output dll_tx_pkg::tlp_class_e         frame_class_o,
  output logic [dll_tx_pkg::SEQ_W-1:0]   seq_num_o
);

  import dll_tx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_CRC_LOW,
    ST_CRC_HIGH
  } framer_st_e;

  framer_st_e       state_r;
  framer_st_e       next_state;
  logic [SEQ_W-1:0] seq_r;
  logic [31:0]      crc_r;
  logic [15:0]      hold_r;
  tlp_class_e       class_r;
  logic [15:0]      lo_half;
  logic [31:0]      step_data;
  logic [31:0]      step_crc;
  logic [31:0]      lcrc_next;
  logic [31:0]      lcrc_r;
  logic             take_head;
  logic             beat_sent;

  // low half is the sequence prefix on beat 0, else the held upper bytes
  assign lo_half = (state_r == ST_IDLE) ? {seq_r[7:0], 4'h0, seq_r[11:8]} : hold_r;

  assign step_data = (state_r == ST_CRC_LOW) ? {16'h0, hold_r}
                                             : {head_i.data[15:0], lo_half};

  lcrc32_step u_lcrc (
    .crc_i (crc_r),
    .data_i(step_data),
    .half_i(state_r == ST_CRC_LOW),
    .crc_o (step_crc)
  );

  assign lcrc_next = ~step_crc;
  assign lcrc_r    = ~crc_r;

  always_comb begin
    next_state      = state_r;
    head_ready_o    = 1'b0;
    out_valid_o     = 1'b0;
    frame_done_o    = 1'b0;
    out_beat_o.data = step_data;
    out_beat_o.keep = 4'b1111;
    out_beat_o.last = 1'b0;
    case (state_r)
      ST_IDLE: begin
        out_valid_o  = head_valid_i && admit_i;
        head_ready_o = out_ready_i && admit_i;
        if (out_ready_i && head_valid_i && admit_i) begin
          next_state = head_i.last ? ST_CRC_LOW : ST_STREAM;
        end
      end
      ST_STREAM: begin
        out_valid_o  = head_valid_i;
        head_ready_o = out_ready_i;
        if (out_ready_i && head_valid_i && head_i.last) begin
          next_state = ST_CRC_LOW;
        end
      end
      ST_CRC_LOW: begin
        // last two tlp bytes, then lcrc bytes 0 and 1
        out_valid_o     = 1'b1;
        out_beat_o.data = {lcrc_next[15:0], hold_r};
        if (out_ready_i) begin
          next_state = ST_CRC_HIGH;
        end
      end
      ST_CRC_HIGH: begin
        out_valid_o     = 1'b1;
        out_beat_o.data = {16'h0, lcrc_r[31:16]};
        out_beat_o.keep = 4'b0011;
        out_beat_o.last = 1'b1;
        frame_done_o    = out_ready_i;
        if (out_ready_i) begin
          next_state = ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  assign take_head = head_valid_i && head_ready_o;
  assign beat_sent = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
      seq_r   <= '0;
      crc_r   <= LCRC_INIT;
    end else begin
      state_r <= next_state;
      if (frame_done_o) begin
        seq_r <= seq_r + 1'b1;
      end
      if (beat_sent) begin
        // crc_high leaves the register ready for the next frame
        crc_r <= (state_r == ST_CRC_HIGH) ? LCRC_INIT : step_crc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_head) begin
      hold_r <= head_i.data[31:16];
    end
    if (take_head && state_r == ST_IDLE) begin
      class_r <= head_class_i;
    end
  end

  assign frame_class_o = class_r;
  assign seq_num_o     = seq_r;

  stall_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
    else $error("framer output changed while stalled");

endmodule

//--- logic/fc_credit_gate.sv
module fc_credit_gate (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::tlp_beat_t  head_i,
  input  logic                   head_valid_i,
  input  dll_tx_pkg::fc_limits_t fc_limit_i,
  input  logic                   frame_done_i,
  input  dll_tx_pkg::tlp_class_e frame_class_i,
  output logic                   admit_o,
  output dll_tx_pkg::tlp_class_e head_class_o
);

  import dll_tx_pkg::*;

  tlp_dw0_u                  dw0;
  logic [2:0][FC_W-1:0]      limit;
  logic [2:0][FC_W-1:0]      used_r;
  logic [2:0]                class_ok;

  // credit is usable when the distance is 1 to FC_WINDOW, mod 256
  function automatic logic window_ok(input logic [FC_W-1:0] lim,
                                     input logic [FC_W-1:0] used);
    logic [FC_W-1:0] window;
    window = lim - used;
    return (window != '0) && (window <= FC_W'(FC_WINDOW));
  endfunction

  assign dw0.raw = head_i.data;

  // indexed by class
  assign limit = {fc_limit_i.cplh, fc_limit_i.nph, fc_limit_i.ph};

  always_comb begin
    if (dw0.hdr.tlp_type == TYPE_CPL) begin
      head_class_o = CLASS_CPL;
    end else if (dw0.hdr.tlp_type == TYPE_MEM && dw0.hdr.fmt[1]) begin
      // fmt bit 1 marks a data payload
      head_class_o = CLASS_P;
    end else begin
      head_class_o = CLASS_NP;
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      class_ok[i] = window_ok(limit[i], used_r[i]);
    end
  end

  assign admit_o = head_valid_i && class_ok[head_class_o];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      used_r <= '0;
    end else if (frame_done_i) begin
      used_r[frame_class_i] <= used_r[frame_class_i] + 1'b1;
    end
  end

  // a frame only finishes for a class that had credit when it started
  done_has_credit_a: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_done_i |-> limit[frame_class_i] != used_r[frame_class_i])
    else $error("frame done for class %0d with no header credit", frame_class_i);

endmodule

//--- logic/lcrc32_step.sv
module lcrc32_step (
  input  logic [31:0] crc_i,
  input  logic [31:0] data_i,
  input  logic        half_i,
  output logic [31:0] crc_o
);

  import dll_tx_pkg::*;

  logic [31:0] crc_c;

  // one byte of the reflected crc-32, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                           input logic [7:0]  din);
    logic [31:0] c;
    c = crc ^ {24'h0, din};
    for (int k = 0; k < 8; k++) begin
      if (c[0]) begin
        c = (c >> 1) ^ LCRC_POLY_REFL;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_comb begin
    crc_c = crc_i;
    // stream order is byte 0 first
    for (int b = 0; b < 4; b++) begin
      if (b < 2 || !half_i) begin
        crc_c = crc_byte(crc_c, data_i[8*b +: 8]);
      end
    end
  end

  assign crc_o = crc_c;

endmodule

//--- logic/tlp_skid_buffer.sv
module tlp_skid_buffer #(
  parameter type beat_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  beat_t s_beat_i,
  input  logic  s_valid_i,
  output logic  s_ready_o,
  output beat_t m_beat_o,
  output logic  m_valid_o,
  input  logic  m_ready_i
);

  beat_t main_r;
  beat_t skid_r;
  logic  main_valid_r;
  logic  skid_valid_r;
  logic  out_free;

  // main slot can take a beat this cycle
  assign out_free = !main_valid_r || m_ready_i;

  // ready comes straight from a flop
  assign s_ready_o = !skid_valid_r;
  assign m_beat_o  = main_r;
  assign m_valid_o = main_valid_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_r <= 1'b0;
      skid_valid_r <= 1'b0;
    end else if (out_free) begin
      main_valid_r <= skid_valid_r || s_valid_i;
      skid_valid_r <= 1'b0;
    end else if (s_valid_i && s_ready_o) begin
      skid_valid_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      // older skid beat goes first
      main_r <= skid_valid_r ? skid_r : s_beat_i;
    end
    if (!out_free && s_ready_o) begin
      skid_r <= s_beat_i;
    end
  end

  hold_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
    else $error("skid buffer output changed while stalled");

endmodule

//--- logic/tlp_tx_datalink.sv
module tlp_tx_datalink (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  dll_tx_pkg::tlp_beat_t          tlp_i,
  input  logic                           tlp_valid_i,
  output logic                           tlp_ready_o,
  output dll_tx_pkg::dllp_beat_t         dllp_o,
  output logic                           dllp_valid_o,
  input  logic                           dllp_ready_i,
  input  dll_tx_pkg::fc_limits_t         fc_limit_i,
  output logic [dll_tx_pkg::SEQ_W-1:0]   seq_num_o
);

  import dll_tx_pkg::*;

  tlp_beat_t  head_beat;
  logic       head_valid;
  logic       head_ready;
  logic       admit;
  tlp_class_e head_class;
  logic       frame_done;
  tlp_class_e frame_class;
  dllp_beat_t fr_beat;
  logic       fr_valid;
  logic       fr_ready;

  tlp_skid_buffer #(
    .beat_t(tlp_beat_t)
  ) u_in_skid (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (tlp_i),
    .s_valid_i(tlp_valid_i),
    .s_ready_o(tlp_ready_o),
    .m_beat_o (head_beat),
    .m_valid_o(head_valid),
    .m_ready_i(head_ready)
  );

  fc_credit_gate u_gate (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_i       (head_beat),
    .head_valid_i (head_valid),
    .fc_limit_i   (fc_limit_i),
    .frame_done_i (frame_done),
    .frame_class_i(frame_class),
    .admit_o      (admit),
    .head_class_o (head_class)
  );

  dllp_framer u_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_i       (head_beat),
    .head_valid_i (head_valid),
    .head_ready_o (head_ready),
    .admit_i      (admit),
    .head_class_i (head_class),
    .out_beat_o   (fr_beat),
    .out_valid_o  (fr_valid),
    .out_ready_i  (fr_ready),
    .frame_done_o (frame_done),
    .frame_class_o(frame_class),
    .seq_num_o    (seq_num_o)
  );

  tlp_skid_buffer #(
    .beat_t(dllp_beat_t)
  ) u_out_skid (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (fr_beat),
    .s_valid_i(fr_valid),
    .s_ready_o(fr_ready),
    .m_beat_o (dllp_o),
    .m_valid_o(dllp_valid_o),
    .m_ready_i(dllp_ready_i)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_tlp_tx_datalink -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

//--- tb/tlp_frame_model.svh
`ifndef TLP_FRAME_MODEL_SVH
`define TLP_FRAME_MODEL_SVH

// reflected crc-32 taken one bit at a time, result complemented
function automatic logic [31:0] frame_lcrc(input logic [7:0] frame_bytes[$]);
  logic [31:0] crc;
  logic        fb;
  crc = LCRC_INIT;
  foreach (frame_bytes[i]) begin
    for (int b = 0; b < 8; b++) begin
      fb = crc[0] ^ frame_bytes[i][b];
      crc = crc >> 1;
      if (fb) begin
        crc = crc ^ LCRC_POLY_REFL;
      end
    end
  end
  return ~crc;
endfunction

// expected output beats of one frame, appended to exp_q
function automatic void push_frame(input logic [SEQ_W-1:0] seq, input logic [31:0] dws[$]);
  logic [7:0]  frame_bytes[$];
  logic [31:0] lcrc;
  dllp_beat_t  beat;
  int          n;
  // reserved nibble, then sequence number msb first
  frame_bytes.push_back({4'h0, seq[11:8]});
  frame_bytes.push_back(seq[7:0]);
  foreach (dws[i]) begin
    for (int k = 0; k < 4; k++) begin
      frame_bytes.push_back(dws[i][8*k +: 8]);
    end
  end
  lcrc = frame_lcrc(frame_bytes);
  // lcrc goes out low byte first
  for (int k = 0; k < 4; k++) begin
    frame_bytes.push_back(lcrc[8*k +: 8]);
  end
  n = frame_bytes.size();
  for (int i = 0; i < n; i += 4) begin
    beat = '0;
    for (int k = 0; k < 4; k++) begin
      if (i + k < n) begin
        beat.data[8*k +: 8] = frame_bytes[i + k];
        beat.keep[k] = 1'b1;
      end
    end
    beat.last = (i + 4 >= n);
    exp_q.push_back(beat);
  end
endfunction

`endif

//--- tb/tb_tlp_tx_datalink.sv
module tb_tlp_tx_datalink;
  timeunit 1ns;
  timeprecision 1ps;

  import dll_tx_pkg::*;

  localparam int          CLK_PERIOD  = 8;
  localparam logic [31:0] RAND_SEED   = 32'h8095;
  localparam int          MAX_DW      = 8;
  localparam int          N_BURST     = 8;
  localparam int          N_MIX       = 20;
  localparam int          NP_DW       = 2;
  localparam int          HOLD_CYCLES = 24;
  // upper bound on output beats over all tests
  localparam int TOTAL_BEATS = 5 + N_BURST * (MAX_DW + 2) + 2 * (NP_DW + 2)
                               + N_MIX * (MAX_DW + 2);
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;

  logic             clk_i;
  logic             rst_i;
  tlp_beat_t        tlp_i;
  logic             tlp_valid_i;
  logic             tlp_ready_o;
  dllp_beat_t       dllp_o;
  logic             dllp_valid_o;
  logic             dllp_ready_i;
  fc_limits_t       fc_limit_i;
  logic [SEQ_W-1:0] seq_num_o;

  dllp_beat_t       exp_q[$];
  dllp_beat_t       exp_beat;
  logic             exp_avail;
  logic [SEQ_W-1:0] seq_next;
  logic [FC_W-1:0]  used_cnt[3];
  logic             random_ready;
  logic             hold_off;
  logic             check_seq;
  int               fail_cnt;
  int               test_fails;
  int               tests_passed;
  int               tests_failed;

  `include "tlp_frame_model.svh"

  tlp_tx_datalink dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tlp_i       (tlp_i),
    .tlp_valid_i (tlp_valid_i),
    .tlp_ready_o (tlp_ready_o),
    .dllp_o      (dllp_o),
    .dllp_valid_o(dllp_valid_o),
    .dllp_ready_i(dllp_ready_i),
    .fc_limit_i  (fc_limit_i),
    .seq_num_o   (seq_num_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // output ready, random in the mixed test
  initial begin
    dllp_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      dllp_ready_i = random_ready ? ($urandom() % 4 != 0) : 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i && dllp_valid_o && dllp_ready_i && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
  end

  // head of the queue, stable across the rising edge
  always @(negedge clk_i) begin
    exp_avail <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_beat <= exp_q[0];
    end
  end

  reset_values_a: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !dllp_valid_o && tlp_ready_o && seq_num_o == '0)
    else begin
      fail_cnt++;
      $display("[FAIL] after reset dllp_valid_o %h tlp_ready_o %h seq_num_o %h",
               $sampled(dllp_valid_o), $sampled(tlp_ready_o), $sampled(seq_num_o));
    end

  beat_expected_a: assert property (@(posedge clk_i) disable iff (rst_i)
    dllp_valid_o && dllp_ready_i |-> exp_avail)
    else begin
      fail_cnt++;
      $display("output beat accepted while no frame beat was expected");
    end

  beat_match_a: assert property (@(posedge clk_i) disable iff (rst_i)
    dllp_valid_o && dllp_ready_i && exp_avail |-> dllp_o == exp_beat)
    else begin
      fail_cnt++;
      $display("[FAIL] dllp_o data %h keep %h last %h, expected data %h keep %h last %h",
               $sampled(dllp_o.data), $sampled(dllp_o.keep), $sampled(dllp_o.last),
               $sampled(exp_beat.data), $sampled(exp_beat.keep), $sampled(exp_beat.last));
    end

  stall_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    dllp_valid_o && !dllp_ready_i |=> dllp_valid_o && $stable(dllp_o))
    else begin
      fail_cnt++;
      $display("output beat changed or vanished while dllp_ready_i was low");
    end

  no_output_a: assert property (@(posedge clk_i) disable iff (rst_i)
    hold_off |-> !dllp_valid_o)
    else begin
      fail_cnt++;
      $display("output beat appeared while the head TLP had no header credit");
    end

  seq_level_a: assert property (@(posedge clk_i) disable iff (rst_i)
    check_seq |-> seq_num_o == seq_next)
    else begin
      fail_cnt++;
      $display("[FAIL] seq_num_o got %h expected %h", $sampled(seq_num_o), $sampled(seq_next));
    end

  // fmt in bits 7:5 and type in bits 4:0 of byte 0
  function automatic logic [7:0] class_byte0(input tlp_class_e cls);
    case (cls)
      CLASS_P:   return {3'b010, 5'b00000};
      CLASS_CPL: return {3'b010, 5'b01010};
      default:   return {3'b000, 5'b00000};
    endcase
  endfunction

  function automatic tlp_class_e random_class(input logic with_np);
    int pick;
    pick = with_np ? int'($urandom() % 3) : int'($urandom() % 2);
    if (pick == 0) begin
      return CLASS_P;
    end else if (pick == 1) begin
      return CLASS_CPL;
    end
    return CLASS_NP;
  endfunction

  // called on a falling edge, returns on the edge after the transfer
  task automatic drive_beat(input tlp_beat_t beat);
    tlp_i = beat;
    tlp_valid_i = 1'b1;
    while (!tlp_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic send_tlp(input tlp_class_e cls, input int ndw);
    logic [31:0] dws[$];
    logic [31:0] word;
    tlp_beat_t   beat;
    for (int i = 0; i < ndw; i++) begin
      word = $urandom();
      if (i == 0) begin
        word[7:0] = class_byte0(cls);
      end
      dws.push_back(word);
    end
    push_frame(seq_next, dws);
    seq_next = seq_next + 1'b1;
    used_cnt[cls] = used_cnt[cls] + 1'b1;
    for (int i = 0; i < ndw; i++) begin
      beat.data = dws[i];
      beat.last = (i == ndw - 1);
      drive_beat(beat);
    end
    tlp_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic pulse_seq_check();
    check_seq = 1'b1;
    @(negedge clk_i);
    check_seq = 1'b0;
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    seq_next = '0;
    for (int i = 0; i < 3; i++) begin
      used_cnt[i] = '0;
    end
  endtask

  task automatic end_test(input string name);
    if (fail_cnt == test_fails) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d failed checks", name, fail_cnt - test_fails);
    end
    test_fails = fail_cnt;
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst_i         = 1'b1;
    tlp_i         = '0;
    tlp_valid_i   = 1'b0;
    fc_limit_i.ph   = 8'd100;
    fc_limit_i.nph  = 8'd100;
    fc_limit_i.cplh = 8'd100;
    random_ready  = 1'b0;
    hold_off      = 1'b0;
    check_seq     = 1'b0;
    fail_cnt      = 0;
    test_fails    = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    apply_reset();

    repeat (4) @(negedge clk_i);
    end_test("1 reset values");

    send_tlp(CLASS_P, 3);
    wait_drained();
    pulse_seq_check();
    end_test("2 single posted frame");

    apply_reset();
    for (int i = 0; i < N_BURST; i++) begin
      send_tlp(random_class(1'b0), 1 + int'($urandom() % MAX_DW));
    end
    wait_drained();
    pulse_seq_check();
    end_test("3 back to back sequence");

    // window empty for non-posted
    fc_limit_i.nph = used_cnt[CLASS_NP];
    hold_off = 1'b1;
    send_tlp(CLASS_NP, NP_DW);
    repeat (HOLD_CYCLES) @(negedge clk_i);
    hold_off = 1'b0;
    fc_limit_i.nph = fc_limit_i.nph + 1'b1;
    wait_drained();
    pulse_seq_check();
    hold_off = 1'b1;
    send_tlp(CLASS_NP, NP_DW);
    repeat (HOLD_CYCLES) @(negedge clk_i);
    hold_off = 1'b0;
    end_test("4 non-posted credit block");
    // let the blocked tlp go before mixed traffic
    fc_limit_i.nph = fc_limit_i.nph + 1'b1;
    wait_drained();

    fc_limit_i.ph   = used_cnt[CLASS_P] + 8'd100;
    fc_limit_i.nph  = used_cnt[CLASS_NP] + 8'd100;
    fc_limit_i.cplh = used_cnt[CLASS_CPL] + 8'd100;
    random_ready = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      send_tlp(random_class(1'b1), 1 + int'($urandom() % MAX_DW));
    end
    wait_drained();
    random_ready = 1'b0;
    pulse_seq_check();
    end_test("5 mixed with back-pressure");

    $display("summary: %0d tests passed, %0d tests failed, %0d failed checks",
             tests_passed, tests_failed, fail_cnt);
    if (fail_cnt == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule
